//--- verilog.f
+incdir+rtl
rtl/uart_alu_pkg.sv
rtl/baud_tick_gen.sv
rtl/uart_receiver.sv
rtl/command_unit.sv
rtl/uart_transmitter.sv
rtl/uart_alu_top.sv
tests/uart_alu_asserts.sv
tests/uart_alu_tb.sv

//--- tests/uart_alu_tb.sv
`timescale 1ns/1ps
`include "uart_alu_macros.svh"

module uart_alu_tb;

	localparam int BIT_CLKS = `UART_OVERSAMPLE * `UART_CLKS_PER_TICK;	// clocks per bit
	localparam int FRAME_CLKS = 10 * BIT_CLKS;	// start, 8 data, stop

	logic clk;
	logic reset;
	logic rx;
	logic tx;
	logic busy;
	logic frame_error;
	integer errors;		// failed checks
	integer checks;		// checks run
	integer fe_count;	// frame_error pulses seen
	integer seed;

	uart_alu_top u_dut
	(
		.clk         (clk),
		.reset       (reset),
		.rx          (rx),
		.tx          (tx),
		.busy        (busy),
		.frame_error (frame_error)
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;	// 40 ns period
	end

	always @(negedge clk)
	begin
		if (frame_error === 1'b1)
			fe_count = fe_count + 1;	// pulse is one clk wide
	end

	// expected result per opcode
	function automatic logic [7:0] alu_model(input uart_alu_pkg::alu_op_t op,
		input logic [7:0] a, input logic [7:0] b);
		logic [15:0] ext;	// a with sign copies above it
		begin
			ext = {{8{a[7]}}, a} >> b[2:0];
			case (op)
				uart_alu_pkg::OP_ADD: alu_model = a + b;
				uart_alu_pkg::OP_SUB: alu_model = a - b;
				uart_alu_pkg::OP_AND: alu_model = a & b;
				uart_alu_pkg::OP_OR:  alu_model = a | b;
				uart_alu_pkg::OP_XOR: alu_model = a ^ b;
				uart_alu_pkg::OP_NOR: alu_model = ~(a | b);
				uart_alu_pkg::OP_SRL: alu_model = a >> b[2:0];
				uart_alu_pkg::OP_SRA: alu_model = ext[7:0];
				default:              alu_model = 8'h00;
			endcase
		end
	endfunction

	task automatic apply_reset();
		begin
			reset = 1'b1;
			rx = 1'b1;
			repeat (2) @(posedge clk);
			#1 reset = 1'b0;
			@(negedge clk);
			checks = checks + 1;
			if (tx !== 1'b1 || busy !== 1'b0)
			begin
				errors = errors + 1;
				$display("error at %0t: tx/busy after reset got %b/%b expected 1/0",
					$time, tx, busy);
			end
		end
	endtask

	task automatic hold_bit(input logic level);
		begin
			@(posedge clk);
			#1 rx = level;
			repeat (BIT_CLKS - 1) @(posedge clk);	// one full bit period
		end
	endtask

	task automatic send_byte(input logic [7:0] data, input logic stop_level);
		integer i;
		begin
			hold_bit(1'b0);	// start bit
			for (i = 0; i < 8; i = i + 1)
				hold_bit(data[i]);	// lsb first
			hold_bit(stop_level);
			if (!stop_level)
				hold_bit(1'b1);	// back to idle so the next start edge is seen
		end
	endtask

	task automatic wait_tx_fall(input integer limit, output logic found);
		integer n;
		logic prev;
		begin
			found = 1'b0;
			n = 0;
			@(negedge clk);
			prev = tx;
			while (!found && n < limit)
			begin
				@(negedge clk);
				if (prev === 1'b1 && tx === 1'b0)
					found = 1'b1;
				prev = tx;
				n = n + 1;
			end
		end
	endtask

	task automatic recv_byte(output logic [7:0] data, output logic ok);
		logic found;
		integer i;
		integer n;
		begin
			data = 8'h00;
			ok = 1'b0;
			wait_tx_fall(4 * FRAME_CLKS, found);
			if (!found)
			begin
				errors = errors + 1;
				$display("timeout at %0t: no start bit seen on tx", $time);
			end
			else
			begin
				repeat (BIT_CLKS / 2) @(negedge clk);	// middle of start bit
				checks = checks + 1;
				if (tx !== 1'b0)
				begin
					errors = errors + 1;
					$display("error at %0t: tx start bit got %b expected 0", $time, tx);
				end
				for (i = 0; i < 8; i = i + 1)
				begin
					repeat (BIT_CLKS) @(negedge clk);
					data[i] = tx;
				end
				repeat (BIT_CLKS) @(negedge clk);	// middle of stop bit
				checks = checks + 1;
				if (tx !== 1'b1)
				begin
					errors = errors + 1;
					$display("error at %0t: tx stop bit got %b expected 1", $time, tx);
				end
				n = 0;
				while (busy !== 1'b0 && n < 2 * BIT_CLKS)
				begin
					@(negedge clk);
					n = n + 1;
				end
				if (busy !== 1'b0)
				begin
					errors = errors + 1;
					$display("busy did not fall after the stop bit at %0t", $time);
				end
				ok = 1'b1;
			end
		end
	endtask

	// sends a, b, opcode and compares the returned frame
	task automatic run_command(input logic [7:0] a, input logic [7:0] b, input logic [7:0] op);
		logic [7:0] got;
		logic [7:0] expected;
		logic ok;
		begin
			expected = alu_model(uart_alu_pkg::alu_op_t'(op), a, b);
			fork
				begin
					send_byte(a, 1'b1);
					send_byte(b, 1'b1);
					send_byte(op, 1'b1);
				end
				recv_byte(got, ok);	// response starts inside the opcode stop bit
			join
			checks = checks + 1;
			if (ok && got !== expected)
			begin
				errors = errors + 1;
				$display("error at %0t: tx data got 0x%02h expected 0x%02h (a %02h b %02h op %02h)",
					$time, got, expected, a, b, op);
			end
		end
	endtask

	task automatic test_add_sub();
		begin
			run_command(8'h12, 8'h34, uart_alu_pkg::OP_ADD);
			run_command(8'hF0, 8'h25, uart_alu_pkg::OP_ADD);	// wraps past 0xff
			run_command(8'h40, 8'h15, uart_alu_pkg::OP_SUB);
			run_command(8'h05, 8'h07, uart_alu_pkg::OP_SUB);	// 0xfe
		end
	endtask

	task automatic test_logic_ops();
		begin
			run_command(8'hCA, 8'h5F, uart_alu_pkg::OP_AND);
			run_command(8'hA0, 8'h05, uart_alu_pkg::OP_OR);
			run_command(8'hFF, 8'h3C, uart_alu_pkg::OP_XOR);
			run_command(8'h81, 8'h18, uart_alu_pkg::OP_NOR);
		end
	endtask

	task automatic test_shifts();
		begin
			run_command(8'h96, 8'h0B, uart_alu_pkg::OP_SRL);	// shift by 3 with zero fill
			run_command(8'h96, 8'h0B, uart_alu_pkg::OP_SRA);	// shift by 3 with sign fill
			run_command(8'h80, 8'h07, uart_alu_pkg::OP_SRA);
		end
	endtask

	task automatic test_unknown_op();
		logic found;
		begin
			fork
				begin
					send_byte(8'h12, 1'b1);
					send_byte(8'h34, 1'b1);
					send_byte(8'h55, 1'b1);	// not an opcode
				end
				wait_tx_fall(6 * FRAME_CLKS, found);	// sending plus three frame times
			join
			checks = checks + 1;
			if (found)
			begin
				errors = errors + 1;
				$display("unknown opcode 0x55 produced a tx frame at %0t", $time);
			end
			run_command(8'h21, 8'h43, uart_alu_pkg::OP_ADD);	// sequencer back at a
		end
	endtask

	task automatic test_framing();
		integer fe_before;
		begin
			fe_before = fe_count;
			send_byte(8'hA5, 1'b0);	// low stop bit
			checks = checks + 1;
			if (fe_count !== fe_before + 1)
			begin
				errors = errors + 1;
				$display("error at %0t: frame_error pulses got %0d expected 1",
					$time, fe_count - fe_before);
			end
			run_command(8'h0F, 8'h30, uart_alu_pkg::OP_OR);
		end
	endtask

	task automatic test_random();
		logic [7:0] ops [0:7];
		logic [31:0] r;
		integer k;
		begin
			ops[0] = uart_alu_pkg::OP_ADD;
			ops[1] = uart_alu_pkg::OP_SUB;
			ops[2] = uart_alu_pkg::OP_AND;
			ops[3] = uart_alu_pkg::OP_OR;
			ops[4] = uart_alu_pkg::OP_XOR;
			ops[5] = uart_alu_pkg::OP_NOR;
			ops[6] = uart_alu_pkg::OP_SRL;
			ops[7] = uart_alu_pkg::OP_SRA;
			for (k = 0; k < 20; k = k + 1)
			begin
				r = $random(seed);
				run_command(r[7:0], r[15:8], ops[r[18:16]]);
			end
		end
	endtask

	initial
	begin
		errors = 0;
		checks = 0;
		fe_count = 0;
		seed = 70;
		rx = 1'b1;
		reset = 1'b1;
		apply_reset();
		test_add_sub();
		test_logic_ops();
		test_shifts();
		test_unknown_op();
		test_framing();
		test_random();
		repeat (BIT_CLKS) @(posedge clk);
		$display("checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

//--- tests/uart_alu_asserts.sv
`timescale 1ns/1ps

module uart_alu_asserts
(
	input logic clk,
	input logic reset,
	input logic strobe,	// tick, byte valid or result valid
	input logic tx,		// serial out, tied high where absent
	input logic busy	// tied low where absent
);

	// every strobe in the design is one clk wide
	property p_strobe_single;
		@(posedge clk) disable iff (reset) strobe |=> !strobe;
	endproperty

	property p_idle_high;
		@(posedge clk) disable iff (reset) !busy |-> tx;	// line idles high
	endproperty

	property p_reset_state;
		@(posedge clk) reset |=> (!busy && tx);	// idle and marking after reset
	endproperty

	a_strobe_single: assert property (p_strobe_single)
		else $error("strobe high on two cycles in a row");
	a_idle_high: assert property (p_idle_high)
		else $error("tx low while transmitter is idle");
	a_reset_state: assert property (p_reset_state)
		else $error("busy or tx wrong after reset");

endmodule

bind baud_tick_gen uart_alu_asserts u_tick_asserts
	(.clk(clk), .reset(reset), .strobe(tick), .tx(1'b1), .busy(1'b0));
bind uart_receiver uart_alu_asserts u_rx_asserts
	(.clk(clk), .reset(reset), .strobe(rx_byte.valid), .tx(1'b1), .busy(1'b0));
bind uart_transmitter uart_alu_asserts u_tx_asserts
	(.clk(clk), .reset(reset), .strobe(result.valid), .tx(tx), .busy(busy));

//--- rtl/uart_alu_top.sv
`timescale 1ns/1ps

module uart_alu_top
(
	input  logic clk,
	input  logic reset,
	input  logic rx,		// command bytes in
	output logic tx,		// result frame out
	output logic busy,		// transmitter active
	output logic frame_error	// pulse per byte with bad stop bit
);

	logic tick;	// shared oversampling tick
	uart_alu_pkg::rx_byte_t rx_byte;
	uart_alu_pkg::result_t result;

	baud_tick_gen u_tick
	(
		.clk   (clk),
		.reset (reset),
		.tick  (tick)
	);

	uart_receiver u_rx
	(
		.clk     (clk),
		.reset   (reset),
		.rx      (rx),
		.tick    (tick),
		.rx_byte (rx_byte)
	);

	command_unit u_cmd
	(
		.clk     (clk),
		.reset   (reset),
		.rx_byte (rx_byte),
		.result  (result)
	);

	uart_transmitter u_tx
	(
		.clk    (clk),
		.reset  (reset),
		.tick   (tick),
		.result (result),
		.tx     (tx),
		.busy   (busy)
	);

	assign frame_error = rx_byte.valid & rx_byte.framing_error;	// one clk wide

endmodule

//--- rtl/uart_transmitter.sv
`timescale 1ns/1ps
`include "uart_alu_macros.svh"

module uart_transmitter
(
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  tick,	// oversampling tick
	input  uart_alu_pkg::result_t result,	// byte to send
	output logic                  tx,	// serial out, idle high
	output logic                  busy	// frame in progress
);

	localparam int TICK_W = $clog2(`UART_OVERSAMPLE);
	localparam int BIT_W = $clog2(`UART_DATA_BITS);
	localparam logic [TICK_W-1:0] LAST_TICK = TICK_W'(`UART_OVERSAMPLE - 1);
	localparam logic [BIT_W-1:0] LAST_BIT = BIT_W'(`UART_DATA_BITS - 1);

	uart_alu_pkg::tx_state_t state_q;
	logic [TICK_W-1:0] tick_cnt_q;	// ticks inside current bit
	logic [BIT_W-1:0] bit_cnt_q;	// data bits sent
	logic [`UART_DATA_BITS-1:0] shreg_q;	// bit 0 is on the line
	logic tx_q;
	logic bit_end;	// last tick of a bit period
	logic load;	// accept a new result

	assign bit_end = tick && (tick_cnt_q == LAST_TICK);
	assign load = (state_q == uart_alu_pkg::TX_IDLE) && result.valid;	// busy drops it

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state_q <= uart_alu_pkg::TX_IDLE;
			tick_cnt_q <= '0;
			bit_cnt_q <= '0;
			tx_q <= 1'b1;
		end
		else
		begin
			if (tick)
				tick_cnt_q <= bit_end ? '0 : tick_cnt_q + 1'b1;
			case (state_q)
				uart_alu_pkg::TX_IDLE:
				begin
					tx_q <= 1'b1;
					tick_cnt_q <= '0;
					if (load)
					begin
						state_q <= uart_alu_pkg::TX_START;
						bit_cnt_q <= '0;
						tx_q <= 1'b0;	// start bit
					end
				end
				uart_alu_pkg::TX_START:
				begin
					if (bit_end)
					begin
						state_q <= uart_alu_pkg::TX_DATA;
						tx_q <= shreg_q[0];	// lsb first
					end
				end
				uart_alu_pkg::TX_DATA:
				begin
					if (bit_end)
					begin
						if (bit_cnt_q == LAST_BIT)
						begin
							state_q <= uart_alu_pkg::TX_STOP;
							tx_q <= 1'b1;	// stop bit
						end
						else
						begin
							bit_cnt_q <= bit_cnt_q + 1'b1;
							tx_q <= shreg_q[1];	// shreg shifts this same clk
						end
					end
				end
				uart_alu_pkg::TX_STOP:
				begin
					if (bit_end)
						state_q <= uart_alu_pkg::TX_IDLE;	// busy falls here
				end
				default:
				begin
					state_q <= uart_alu_pkg::TX_IDLE;
					tx_q <= 1'b1;
				end
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (load)
			shreg_q <= result.data;	// latch result on start
		else if (state_q == uart_alu_pkg::TX_DATA && bit_end)
			shreg_q <= shreg_q >> 1;
	end

	assign tx = tx_q;
	assign busy = (state_q != uart_alu_pkg::TX_IDLE);

endmodule

//--- rtl/command_unit.sv
`timescale 1ns/1ps
`include "uart_alu_macros.svh"

module command_unit
(
	input  logic                   clk,
	input  logic                   reset,
	input  uart_alu_pkg::rx_byte_t rx_byte,	// from receiver
	output uart_alu_pkg::result_t  result	// to transmitter
);

	localparam int SHIFT_W = $clog2(`UART_DATA_BITS);

	uart_alu_pkg::seq_state_t seq_q;	// which byte comes next
	uart_alu_pkg::alu_op_t op;
	logic [`UART_DATA_BITS-1:0] a_q;	// operand a
	logic [`UART_DATA_BITS-1:0] b_q;	// operand b
	logic [`UART_DATA_BITS-1:0] alu_out;
	logic op_legal;			// opcode is one of alu_op_t
	logic res_valid_q;
	logic [`UART_DATA_BITS-1:0] res_data_q;
	logic good_byte;

	assign good_byte = rx_byte.valid && !rx_byte.framing_error;
	assign op = uart_alu_pkg::alu_op_t'(rx_byte.data);	// incoming byte seen as opcode

	always_comb
	begin
		op_legal = 1'b1;
		alu_out = '0;
		case (op)
			uart_alu_pkg::OP_ADD: alu_out = a_q + b_q;	// wraps to 8 bits
			uart_alu_pkg::OP_SUB: alu_out = a_q - b_q;
			uart_alu_pkg::OP_AND: alu_out = a_q & b_q;
			uart_alu_pkg::OP_OR:  alu_out = a_q | b_q;
			uart_alu_pkg::OP_XOR: alu_out = a_q ^ b_q;
			uart_alu_pkg::OP_NOR: alu_out = ~(a_q | b_q);
			uart_alu_pkg::OP_SRL: alu_out = a_q >> b_q[SHIFT_W-1:0];
			uart_alu_pkg::OP_SRA: alu_out = $signed(a_q) >>> b_q[SHIFT_W-1:0];	// sign fill
			default:              op_legal = 1'b0;	// unknown code gives no result
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			seq_q <= uart_alu_pkg::SEQ_GET_A;
			res_valid_q <= 1'b0;
		end
		else
		begin
			res_valid_q <= 1'b0;	// strobe lasts one clk
			if (rx_byte.valid)
			begin
				if (rx_byte.framing_error)
					seq_q <= uart_alu_pkg::SEQ_GET_A;	// drop byte and resync
				else
				begin
					case (seq_q)
						uart_alu_pkg::SEQ_GET_A:  seq_q <= uart_alu_pkg::SEQ_GET_B;
						uart_alu_pkg::SEQ_GET_B:  seq_q <= uart_alu_pkg::SEQ_GET_OP;
						uart_alu_pkg::SEQ_GET_OP:
						begin
							seq_q <= uart_alu_pkg::SEQ_GET_A;
							res_valid_q <= op_legal;
						end
						default:                  seq_q <= uart_alu_pkg::SEQ_GET_A;
					endcase
				end
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (good_byte && seq_q == uart_alu_pkg::SEQ_GET_A)
			a_q <= rx_byte.data;
		if (good_byte && seq_q == uart_alu_pkg::SEQ_GET_B)
			b_q <= rx_byte.data;
		if (good_byte && seq_q == uart_alu_pkg::SEQ_GET_OP)
			res_data_q <= alu_out;	// registered alu result
	end

	assign result.valid = res_valid_q;
	assign result.data = res_data_q;

endmodule

//--- rtl/uart_receiver.sv
`timescale 1ns/1ps
`include "uart_alu_macros.svh"

module uart_receiver
(
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   rx,		// serial in, idle high
	input  logic                   tick,		// oversampling tick
	output uart_alu_pkg::rx_byte_t rx_byte	// byte strobe to command unit
);

	localparam int TICK_W = $clog2(`UART_OVERSAMPLE);
	localparam int BIT_W = $clog2(`UART_DATA_BITS);
	localparam logic [TICK_W-1:0] MID_TICK = TICK_W'(`UART_OVERSAMPLE / 2 - 1);
	localparam logic [TICK_W-1:0] LAST_TICK = TICK_W'(`UART_OVERSAMPLE - 1);
	localparam logic [BIT_W-1:0] LAST_BIT = BIT_W'(`UART_DATA_BITS - 1);

	logic rx_meta;	// first sync flop
	logic rx_sync;	// second sync flop, safe to use
	logic rx_prev;	// delayed copy for edge detect
	uart_alu_pkg::rx_state_t state_q;
	uart_alu_pkg::rx_state_t state_d;
	logic [TICK_W-1:0] tick_cnt_q;	// ticks inside current bit
	logic [TICK_W-1:0] tick_cnt_d;
	logic [BIT_W-1:0] bit_cnt_q;	// data bits taken so far
	logic [BIT_W-1:0] bit_cnt_d;
	logic [`UART_DATA_BITS-1:0] shreg_q;	// lsb arrives first
	logic [`UART_DATA_BITS-1:0] shreg_d;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			rx_meta <= 1'b1;	// line idles high
			rx_sync <= 1'b1;
			rx_prev <= 1'b1;
			state_q <= uart_alu_pkg::RX_WAIT;
			tick_cnt_q <= '0;
			bit_cnt_q <= '0;
		end
		else
		begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
			rx_prev <= rx_sync;
			state_q <= state_d;
			tick_cnt_q <= tick_cnt_d;
			bit_cnt_q <= bit_cnt_d;
		end
	end

	always_ff @(posedge clk)
	begin
		shreg_q <= shreg_d;	// data only
	end

	always_comb
	begin
		state_d = state_q;
		tick_cnt_d = tick_cnt_q;
		bit_cnt_d = bit_cnt_q;
		shreg_d = shreg_q;
		rx_byte.valid = 1'b0;
		rx_byte.framing_error = ~rx_sync;	// stop level, only read with valid
		rx_byte.data = shreg_q;
		case (state_q)
			uart_alu_pkg::RX_WAIT:
			begin
				if (rx_prev && !rx_sync)	// falling edge starts a frame
				begin
					state_d = uart_alu_pkg::RX_START;
					tick_cnt_d = '0;
				end
			end
			uart_alu_pkg::RX_START:
			begin
				if (tick)
				begin
					if (tick_cnt_q == MID_TICK)	// middle of start bit
					begin
						tick_cnt_d = '0;
						bit_cnt_d = '0;
						// a high line here means a glitch and not a start bit
						state_d = rx_sync ? uart_alu_pkg::RX_WAIT : uart_alu_pkg::RX_DATA;
					end
					else
						tick_cnt_d = tick_cnt_q + 1'b1;
				end
			end
			uart_alu_pkg::RX_DATA:
			begin
				if (tick)
				begin
					if (tick_cnt_q == LAST_TICK)	// middle of next data bit
					begin
						tick_cnt_d = '0;
						shreg_d = {rx_sync, shreg_q[`UART_DATA_BITS-1:1]};
						if (bit_cnt_q == LAST_BIT)
							state_d = uart_alu_pkg::RX_STOP;
						else
							bit_cnt_d = bit_cnt_q + 1'b1;
					end
					else
						tick_cnt_d = tick_cnt_q + 1'b1;
				end
			end
			uart_alu_pkg::RX_STOP:
			begin
				if (tick)
				begin
					if (tick_cnt_q == LAST_TICK)	// middle of stop bit
					begin
						rx_byte.valid = 1'b1;
						state_d = uart_alu_pkg::RX_WAIT;
					end
					else
						tick_cnt_d = tick_cnt_q + 1'b1;
				end
			end
			default:	// illegal code, recover to idle
			begin
				state_d = uart_alu_pkg::RX_WAIT;
				tick_cnt_d = '0;
				bit_cnt_d = '0;
			end
		endcase
	end

endmodule

//--- rtl/baud_tick_gen.sv
`timescale 1ns/1ps
`include "uart_alu_macros.svh"

module baud_tick_gen
(
	input  logic clk,
	input  logic reset,
	output logic tick	// one clk wide, shared by rx and tx
);

	localparam int CNT_W = $clog2(`UART_CLKS_PER_TICK);
	localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(`UART_CLKS_PER_TICK - 1);

	logic [CNT_W-1:0] cnt_q;	// free-running divider

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			cnt_q <= '0;
			tick <= 1'b0;
		end
		else
		begin
			tick <= (cnt_q == LAST_CNT);	// pulse on wrap
			cnt_q <= (cnt_q == LAST_CNT) ? '0 : cnt_q + 1'b1;
		end
	end

endmodule

//--- rtl/uart_alu_pkg.sv
`include "uart_alu_macros.svh"

package uart_alu_pkg;

	typedef enum logic [`UART_DATA_BITS-1:0]
	{
		OP_ADD = 8'h20,	// a + b, wraps
		OP_SUB = 8'h22,	// a - b, wraps
		OP_AND = 8'h24,
		OP_OR  = 8'h25,
		OP_XOR = 8'h26,
		OP_NOR = 8'h27,
		OP_SRL = 8'h02,	// logical shift right
		OP_SRA = 8'h03	// arithmetic shift right
	} alu_op_t;

	// one-cold receiver states, a single zero marks the state
	typedef enum logic [3:0]
	{
		RX_WAIT  = 4'b1110,	// line idle, looking for start edge
		RX_START = 4'b1101,	// counting to middle of start bit
		RX_DATA  = 4'b1011,	// sampling data bits
		RX_STOP  = 4'b0111	// sampling stop bit
	} rx_state_t;

	typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_t;

	typedef enum logic [1:0] {SEQ_GET_A, SEQ_GET_B, SEQ_GET_OP} seq_state_t;

	typedef struct packed
	{
		logic                       valid;		// one-cycle strobe
		logic                       framing_error;	// stop bit sampled low
		logic [`UART_DATA_BITS-1:0] data;
	} rx_byte_t;

	typedef struct packed
	{
		logic                       valid;		// one-cycle strobe
		logic [`UART_DATA_BITS-1:0] data;
	} result_t;

endpackage

//--- rtl/uart_alu_macros.svh
`ifndef UART_ALU_MACROS_SVH
`define UART_ALU_MACROS_SVH

// data bits per 8N1 frame
`define UART_DATA_BITS 8

// ticks per bit period
`define UART_OVERSAMPLE 16

// clk cycles between two ticks
// one bit period is UART_OVERSAMPLE * UART_CLKS_PER_TICK = 32 clocks
`define UART_CLKS_PER_TICK 2

`endif
